// File: verilog.f
verilog/noc_pkg.sv
verilog/noc_packet_packer.sv
verilog/noc_vc_buffer.sv
verilog/noc_vc_arbiter.sv
verilog/noc_packet_unpacker.sv
verilog/noc_loopback_top.sv
verification/noc_clock_gen.sv
verification/noc_loopback_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module noc_loopback_tb -f verilog.f -o noc_loopback_sim

./obj_dir/noc_loopback_sim | tee sim.log

if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"

// File: verification/noc_loopback_tb.sv
`timescale 1ns/10ps

module noc_loopback_tb import noc_pkg::*; ();

  localparam int num_packets = 200;
  localparam int max_beats   = 8;
  localparam int cycle_limit = num_packets * 10 * 4;

  logic            clk;
  logic            rst_n;
  logic            header_valid;
  logic            header_ready;
  noc_packet_type  packet_type;
  noc_id           destination_id;
  noc_id           source_id;
  noc_vc           vc;
  noc_tag          tag;
  noc_burst_length burst_length;
  noc_address      address;
  noc_status       status;
  logic            payload_valid;
  logic            payload_ready;
  noc_data         data;
  noc_byte_enable  byte_enable;
  logic            payload_last;
  logic            out_header_valid;
  logic            out_header_ready;
  noc_packet_type  out_packet_type;
  noc_id           out_destination_id;
  noc_id           out_source_id;
  noc_vc           out_vc;
  noc_tag          out_tag;
  noc_burst_length out_burst_length;
  noc_address      out_address;
  noc_status       out_status;
  logic            out_payload_valid;
  logic            out_payload_ready;
  noc_data         out_data;
  noc_byte_enable  out_byte_enable;
  logic            out_payload_last;

  // every packet sent is kept here under its packet number
  noc_packet_type  pkt_type [num_packets];
  noc_id           pkt_dest [num_packets];
  noc_id           pkt_src [num_packets];
  noc_vc           pkt_vc [num_packets];
  noc_tag          pkt_tag [num_packets];
  noc_burst_length pkt_burst [num_packets];
  noc_address      pkt_addr [num_packets];
  noc_status       pkt_status [num_packets];
  logic            pkt_with_payload [num_packets];
  noc_data         pkt_data [num_packets][max_beats];
  noc_byte_enable  pkt_be [num_packets][max_beats];
  int              vc_queue [noc_vcs][$];  // packet numbers in flight on each channel

  int current = -1;  // packet whose payload is being received
  int beat_seen = 0;
  int received = 0;
  int cycle_count = 0;
  int check_count = 0;
  int mismatch_count = 0;
  int failure_count = 0;

  noc_clock_gen clock_i (
    .clk (clk)
  );

  noc_loopback_top noc_loopback_top_i (.*);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checking helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      mismatch_count++;
      $display("error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
    end
  endtask

  task automatic report_failure(input string message);
    failure_count++;
    $display("failure at %0t: %s", $time, message);
  endtask

  task automatic print_summary();
    $display("checks %0d, mismatches %0d, other failures %0d, packets received %0d of %0d",
             check_count, mismatch_count, failure_count, received, num_packets);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // packet input side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic send_packet(input int idx);
    int   beat;
    logic accepted;
    pkt_type[idx]   = noc_packet_type'(2'($urandom_range(3, 0)));
    pkt_dest[idx]   = noc_id'($urandom_range(15, 0));
    pkt_src[idx]    = noc_id'($urandom_range(15, 0));
    pkt_vc[idx]     = noc_vc'($urandom_range(1, 0));
    pkt_tag[idx]    = noc_tag'($urandom_range(15, 0));
    pkt_burst[idx]  = noc_burst_length'($urandom_range(7, 0));
    pkt_addr[idx]   = noc_address'($urandom);
    pkt_status[idx] = noc_status'($urandom_range(3, 0));
    pkt_with_payload[idx] = (pkt_type[idx] == write_request) ||
                            (pkt_type[idx] == read_response);
    for (int b = 0; b < max_beats; b++) begin
      pkt_data[idx][b] = noc_data'($urandom);
      pkt_be[idx][b]   = noc_byte_enable'($urandom_range(3, 0));
    end
    vc_queue[pkt_vc[idx]].push_back(idx);

    packet_type    = pkt_type[idx];  // fields stay put until the last payload beat
    destination_id = pkt_dest[idx];
    source_id      = pkt_src[idx];
    vc             = pkt_vc[idx];
    tag            = pkt_tag[idx];
    burst_length   = pkt_burst[idx];
    address        = pkt_addr[idx];
    status         = pkt_status[idx];
    header_valid   = 1'b1;
    accepted       = 1'b0;
    while (!accepted) begin
      #1;
      accepted = header_ready;  // ready only comes with the last header flit
      @(negedge clk);
    end
    header_valid = 1'b0;

    if (pkt_with_payload[idx]) begin
      beat = 0;
      while (beat <= int'(pkt_burst[idx])) begin
        payload_valid = 1'b1;
        data          = pkt_data[idx][beat];
        byte_enable   = pkt_be[idx][beat];
        payload_last  = (beat == int'(pkt_burst[idx]));
        #1;
        if (payload_ready) begin
          beat++;
        end
        @(negedge clk);
      end
      payload_valid = 1'b0;
      payload_last  = 1'b0;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_header();
    int idx;
    if (current >= 0) begin
      report_failure($sformatf("packet %0d ended after %0d of %0d payload beats",
                               current, beat_seen, int'(pkt_burst[current]) + 1));
    end
    current = -1;
    if (vc_queue[out_vc].size() == 0) begin
      report_failure($sformatf("header on vc %0d with no packet outstanding", out_vc));
    end else begin
      idx = vc_queue[out_vc].pop_front();
      compare_value($sformatf("packet %0d type", idx), pkt_type[idx], out_packet_type);
      compare_value($sformatf("packet %0d destination", idx), pkt_dest[idx],
                    out_destination_id);
      compare_value($sformatf("packet %0d source", idx), pkt_src[idx], out_source_id);
      compare_value($sformatf("packet %0d tag", idx), pkt_tag[idx], out_tag);
      if (pkt_type[idx] == read_request || pkt_type[idx] == write_request) begin
        compare_value($sformatf("packet %0d burst_length", idx), pkt_burst[idx],
                      out_burst_length);
        compare_value($sformatf("packet %0d address", idx), pkt_addr[idx], out_address);
      end else begin
        compare_value($sformatf("packet %0d status", idx), pkt_status[idx], out_status);
      end
      received++;
      if (pkt_with_payload[idx]) begin
        current   = idx;
        beat_seen = 0;
      end
    end
  endtask

  task automatic check_payload();
    if (current < 0) begin
      report_failure("payload beat seen with no payload packet open");
    end else if (beat_seen > int'(pkt_burst[current])) begin
      report_failure($sformatf("packet %0d has more than %0d payload beats",
                               current, int'(pkt_burst[current]) + 1));
    end else begin
      compare_value($sformatf("packet %0d beat %0d data", current, beat_seen),
                    pkt_data[current][beat_seen], out_data);
      compare_value($sformatf("packet %0d beat %0d byte_enable", current, beat_seen),
                    pkt_be[current][beat_seen], out_byte_enable);
      compare_value($sformatf("packet %0d beat %0d payload_last", current, beat_seen),
                    beat_seen == int'(pkt_burst[current]), out_payload_last);
      beat_seen++;
      if (out_payload_last) begin
        current = -1;
      end
    end
  endtask

  initial begin : receiver
    out_header_ready  = 1'b0;
    out_payload_ready = 1'b0;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      out_header_ready  = ($urandom_range(99, 0) < 70);
      out_payload_ready = ($urandom_range(99, 0) < 70);
      #1;  // outputs have settled well before the next rising edge
      if (out_header_valid && out_header_ready) begin
        check_header();
      end
      if (out_payload_valid && out_payload_ready) begin
        check_payload();
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      report_failure($sformatf("timeout after %0d cycles with packets still missing",
                               cycle_limit));
      print_summary();
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    void'($urandom(32'h57a5_072f));
    rst_n          = 1'b0;
    header_valid   = 1'b0;
    packet_type    = read_request;
    destination_id = '0;
    source_id      = '0;
    vc             = '0;
    tag            = '0;
    burst_length   = '0;
    address        = '0;
    status         = '0;
    payload_valid  = 1'b0;
    data           = '0;
    byte_enable    = '0;
    payload_last   = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    @(negedge clk);
    #1;
    compare_value("idle out_header_valid", 1'b0, out_header_valid);
    compare_value("idle out_payload_valid", 1'b0, out_payload_valid);
    compare_value("idle header_ready", 1'b0, header_ready);
    compare_value("idle payload_ready", 1'b0, payload_ready);
    @(negedge clk);

    for (int idx = 0; idx < num_packets; idx++) begin
      send_packet(idx);
    end

    wait (received == num_packets && current < 0);
    repeat (20) @(negedge clk);  // a duplicate header would show up here

    print_summary();
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: verification/noc_clock_gen.sv
`timescale 1ns/10ps

module noc_clock_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;  // half of the 4 ns period
    end
  end

endmodule

// File: verilog/noc_loopback_top.sv
`timescale 1ns/10ps

module noc_loopback_top import noc_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            header_valid,
  output logic            header_ready,
  input  noc_packet_type  packet_type,
  input  noc_id           destination_id,
  input  noc_id           source_id,
  input  noc_vc           vc,
  input  noc_tag          tag,
  input  noc_burst_length burst_length,
  input  noc_address      address,
  input  noc_status       status,
  input  logic            payload_valid,
  output logic            payload_ready,
  input  noc_data         data,
  input  noc_byte_enable  byte_enable,
  input  logic            payload_last,
  output logic            out_header_valid,
  input  logic            out_header_ready,
  output noc_packet_type  out_packet_type,
  output noc_id           out_destination_id,
  output noc_id           out_source_id,
  output noc_vc           out_vc,
  output noc_tag          out_tag,
  output noc_burst_length out_burst_length,
  output noc_address      out_address,
  output noc_status       out_status,
  output logic            out_payload_valid,
  input  logic            out_payload_ready,
  output noc_data         out_data,
  output noc_byte_enable  out_byte_enable,
  output logic            out_payload_last
);

  // packer to buffers
  logic [noc_vcs-1:0]  in_flit_valid;
  logic [noc_vcs-1:0]  in_flit_ready;
  noc_flit_type        in_flit_type;
  logic                in_head;
  logic                in_tail;
  noc_flit_data        in_flit_data;

  // buffers to arbiter
  logic [noc_vcs-1:0]  buf_valid;
  logic [noc_vcs-1:0]  buf_ready;
  noc_flit_type        buf_flit_type [noc_vcs];
  logic [noc_vcs-1:0]  buf_head;
  logic [noc_vcs-1:0]  buf_tail;
  noc_flit_data        buf_flit_data [noc_vcs];

  // arbiter to unpacker
  logic                arb_valid;
  logic                arb_ready;
  noc_flit_type        arb_flit_type;
  logic                arb_head;
  logic                arb_tail;
  noc_flit_data        arb_flit_data;

  noc_packet_packer packer_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .header_valid   (header_valid),
    .header_ready   (header_ready),
    .packet_type    (packet_type),
    .destination_id (destination_id),
    .source_id      (source_id),
    .vc             (vc),
    .tag            (tag),
    .burst_length   (burst_length),
    .address        (address),
    .status         (status),
    .payload_valid  (payload_valid),
    .payload_ready  (payload_ready),
    .data           (data),
    .byte_enable    (byte_enable),
    .payload_last   (payload_last),
    .flit_valid     (in_flit_valid),
    .flit_ready     (in_flit_ready),
    .flit_type      (in_flit_type),
    .head           (in_head),
    .tail           (in_tail),
    .flit_data      (in_flit_data)
  );

  for (genvar i = 0; i < noc_vcs; i++) begin : g_vc_buffer
    noc_vc_buffer vc_buffer_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .write_valid    (in_flit_valid[i]),
      .write_ready    (in_flit_ready[i]),
      .flit_type      (in_flit_type),
      .head           (in_head),
      .tail           (in_tail),
      .flit_data      (in_flit_data),
      .read_valid     (buf_valid[i]),
      .read_ready     (buf_ready[i]),
      .read_flit_type (buf_flit_type[i]),
      .read_head      (buf_head[i]),
      .read_tail      (buf_tail[i]),
      .read_flit_data (buf_flit_data[i])
    );
  end

  noc_vc_arbiter arbiter_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .request_valid      (buf_valid),
    .request_ready      (buf_ready),
    .request_flit_type  (buf_flit_type),
    .request_head       (buf_head),
    .request_tail       (buf_tail),
    .request_flit_data  (buf_flit_data),
    .flit_valid         (arb_valid),
    .flit_ready         (arb_ready),
    .flit_type          (arb_flit_type),
    .head               (arb_head),
    .tail               (arb_tail),
    .flit_data          (arb_flit_data)
  );

  noc_packet_unpacker unpacker_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .flit_valid         (arb_valid),
    .flit_ready         (arb_ready),
    .flit_type          (arb_flit_type),
    .head               (arb_head),
    .tail               (arb_tail),
    .flit_data          (arb_flit_data),
    .out_header_valid   (out_header_valid),
    .out_header_ready   (out_header_ready),
    .out_packet_type    (out_packet_type),
    .out_destination_id (out_destination_id),
    .out_source_id      (out_source_id),
    .out_vc             (out_vc),
    .out_tag            (out_tag),
    .out_burst_length   (out_burst_length),
    .out_address        (out_address),
    .out_status         (out_status),
    .out_payload_valid  (out_payload_valid),
    .out_payload_ready  (out_payload_ready),
    .out_data           (out_data),
    .out_byte_enable    (out_byte_enable),
    .out_payload_last   (out_payload_last)
  );

endmodule

// File: verilog/noc_packet_unpacker.sv
`timescale 1ns/10ps

module noc_packet_unpacker import noc_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            flit_valid,
  output logic            flit_ready,
  input  noc_flit_type    flit_type,
  input  logic            head,
  input  logic            tail,
  input  noc_flit_data    flit_data,
  output logic            out_header_valid,
  input  logic            out_header_ready,
  output noc_packet_type  out_packet_type,
  output noc_id           out_destination_id,
  output noc_id           out_source_id,
  output noc_vc           out_vc,
  output noc_tag          out_tag,
  output noc_burst_length out_burst_length,
  output noc_address      out_address,
  output noc_status       out_status,
  output logic            out_payload_valid,
  input  logic            out_payload_ready,
  output noc_data         out_data,
  output noc_byte_enable  out_byte_enable,
  output logic            out_payload_last
);

  typedef enum logic [1:0] {
    collect,
    header_hold,
    payload
  } unpacker_state;

  unpacker_state                  state;
  logic [header_data_width-1:0]   header_q;
  logic [header_count_width-1:0]  flit_count;
  logic [header_count_width-1:0]  word;
  noc_packet_type                 flit_packet_type;
  logic                           header_accept;
  logic                           header_last;

  // a head flit always restarts collection at word zero
  assign word             = head ? '0 : flit_count;
  assign flit_packet_type = head ? noc_packet_type'(flit_data[type_lsb +: 2]) : out_packet_type;
  assign header_last      = (word == last_header_flit(flit_packet_type));
  assign header_accept    = (state == collect) && flit_valid && (flit_type == header_flit);

  assign flit_ready = ((state == collect) && (flit_type == header_flit)) ||
                      ((state == payload) && (flit_type == payload_flit) && out_payload_ready);

  always_ff @(posedge clk) begin
    if (header_accept) begin
      header_q[word*flit_data_width +: flit_data_width] <= flit_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= collect;
      flit_count <= '0;
    end else begin
      case (state)
        collect: begin
          if (header_accept) begin
            flit_count <= header_last ? '0 : word + 1'b1;
            if (header_last) begin
              state <= header_hold;
            end
          end
        end
        header_hold: begin
          if (out_header_ready) begin
            state <= has_payload(out_packet_type) ? payload : collect;
          end
        end
        default: begin
          if (out_payload_valid && out_payload_ready && tail) begin
            state <= collect;
          end
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // outputs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign out_header_valid   = (state == header_hold);
  assign out_packet_type    = noc_packet_type'(header_q[type_lsb +: 2]);
  assign out_destination_id = header_q[destination_lsb +: $bits(noc_id)];
  assign out_source_id      = header_q[source_lsb +: $bits(noc_id)];
  assign out_vc             = header_q[vc_lsb +: $bits(noc_vc)];
  assign out_tag            = header_q[tag_lsb +: $bits(noc_tag)];
  assign out_burst_length   = header_q[burst_length_lsb +: $bits(noc_burst_length)];
  assign out_address        = header_q[address_lsb +: $bits(noc_address)];
  assign out_status         = header_q[status_lsb +: $bits(noc_status)];  // overlaps burst_length

  assign out_payload_valid = (state == payload) && flit_valid && (flit_type == payload_flit);
  assign out_data          = flit_data[payload_data_lsb +: $bits(noc_data)];
  assign out_byte_enable   = flit_data[byte_enable_lsb +: $bits(noc_byte_enable)];
  assign out_payload_last  = tail;

endmodule

// File: verilog/noc_vc_arbiter.sv
`timescale 1ns/10ps

module noc_vc_arbiter import noc_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [noc_vcs-1:0]  request_valid,
  output logic [noc_vcs-1:0]  request_ready,
  input  noc_flit_type        request_flit_type [noc_vcs],
  input  logic [noc_vcs-1:0]  request_head,
  input  logic [noc_vcs-1:0]  request_tail,
  input  noc_flit_data        request_flit_data [noc_vcs],
  output logic                flit_valid,
  input  logic                flit_ready,
  output noc_flit_type        flit_type,
  output logic                head,
  output logic                tail,
  output noc_flit_data        flit_data
);

  logic                 lock;
  logic [noc_vcs-1:0]   grant_q;
  logic [noc_vcs-1:0]   pick;
  logic [noc_vcs-1:0]   grant;
  noc_vc                rr_ptr;
  noc_vc                sel;
  logic                 flit_ack;

  // round robin search from the priority pointer, heads only
  always_comb begin
    noc_vc idx;
    logic  found;
    pick  = '0;
    found = 1'b0;
    for (int i = 0; i < noc_vcs; i++) begin
      idx = noc_vc'((int'(rr_ptr) + i) % noc_vcs);
      if (!found && request_valid[idx] && request_head[idx]) begin
        pick[idx] = 1'b1;
        found     = 1'b1;
      end
    end
  end

  assign grant = lock ? grant_q : pick;

  always_comb begin
    sel = '0;
    for (int i = 0; i < noc_vcs; i++) begin
      if (grant[i]) begin
        sel = noc_vc'(i);
      end
    end
  end

  assign request_ready = grant & {noc_vcs{flit_ready}};
  assign flit_valid    = |(request_valid & grant);
  assign flit_type     = request_flit_type[sel];
  assign head          = request_head[sel];
  assign tail          = request_tail[sel];
  assign flit_data     = request_flit_data[sel];
  assign flit_ack      = flit_valid && flit_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lock    <= 1'b0;
      grant_q <= '0;
      rr_ptr  <= '0;
    end else if (flit_ack) begin
      if (tail) begin
        lock   <= 1'b0;
        rr_ptr <= noc_vc'((int'(sel) + 1) % noc_vcs);  // the other channel goes first next
      end else if (head) begin
        lock    <= 1'b1;
        grant_q <= grant;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) lock |-> $onehot(grant_q))
    else $error("vc_arbiter: grant not one-hot while locked");

endmodule

// File: verilog/noc_vc_buffer.sv
`timescale 1ns/10ps

module noc_vc_buffer import noc_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          write_valid,
  output logic          write_ready,
  input  noc_flit_type  flit_type,
  input  logic          head,
  input  logic          tail,
  input  noc_flit_data  flit_data,
  output logic          read_valid,
  input  logic          read_ready,
  output noc_flit_type  read_flit_type,
  output logic          read_head,
  output logic          read_tail,
  output noc_flit_data  read_flit_data
);

  noc_flit_type                     type_mem [vc_buffer_depth];
  logic                             head_mem [vc_buffer_depth];
  logic                             tail_mem [vc_buffer_depth];
  noc_flit_data                     data_mem [vc_buffer_depth];
  logic [buffer_pointer_width-1:0]  read_ptr;
  logic [buffer_pointer_width-1:0]  write_addr;
  logic [buffer_pointer_width:0]    count;
  logic                             write_en;
  logic                             read_en;

  assign write_ready = (count != vc_buffer_depth);
  assign read_valid  = (count != '0);
  assign write_en    = write_valid && write_ready;
  assign read_en     = read_valid && read_ready;
  assign write_addr  = read_ptr + count[buffer_pointer_width-1:0];  // wraps past the last entry

  always_ff @(posedge clk) begin
    if (write_en) begin
      type_mem[write_addr] <= flit_type;
      head_mem[write_addr] <= head;
      tail_mem[write_addr] <= tail;
      data_mem[write_addr] <= flit_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      read_ptr <= '0;
      count    <= '0;
    end else begin
      if (read_en) begin
        read_ptr <= read_ptr + 1'b1;
      end
      count <= count + write_en - read_en;
    end
  end

  assign read_flit_type = type_mem[read_ptr];
  assign read_head      = head_mem[read_ptr];
  assign read_tail      = tail_mem[read_ptr];
  assign read_flit_data = data_mem[read_ptr];

  // a flit refused by a full buffer is offered again unchanged
  assert property (@(posedge clk) disable iff (!rst_n)
    (write_valid && !write_ready) |=> (write_valid && $stable(flit_data) && $stable(tail)))
    else $error("vc_buffer: flit withdrawn while the buffer was full");

endmodule

// File: verilog/noc_packet_packer.sv
`timescale 1ns/10ps

module noc_packet_packer import noc_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                header_valid,
  output logic                header_ready,
  input  noc_packet_type      packet_type,
  input  noc_id               destination_id,
  input  noc_id               source_id,
  input  noc_vc               vc,
  input  noc_tag              tag,
  input  noc_burst_length     burst_length,
  input  noc_address          address,
  input  noc_status           status,
  input  logic                payload_valid,
  output logic                payload_ready,
  input  noc_data             data,
  input  noc_byte_enable      byte_enable,
  input  logic                payload_last,
  output logic [noc_vcs-1:0]  flit_valid,
  input  logic [noc_vcs-1:0]  flit_ready,
  output noc_flit_type        flit_type,
  output logic                head,
  output logic                tail,
  output noc_flit_data        flit_data
);

  typedef enum logic {
    send_header,
    send_payload
  } packer_state;

  packer_state                    state;
  logic [header_count_width-1:0]  flit_count;
  logic [header_data_width-1:0]   header_data;
  noc_vc                          vc_latched;
  noc_vc                          flit_vc;
  logic                           header_last;
  logic                           no_payload;
  logic                           any_valid;
  logic                           selected_ready;
  logic                           flit_ack;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // header packing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    header_data = '0;
    header_data[common_header_width-1:0] = {tag, vc, source_id, destination_id, packet_type};
    if (is_request_packet_type(packet_type)) begin
      header_data[request_header_width-1:common_header_width] = {address, burst_length};
    end else begin
      header_data[response_header_width-1:common_header_width] = status;
    end
  end

  assign no_payload  = !has_payload(packet_type);
  assign header_last = (flit_count == last_header_flit(packet_type));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flit link
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign flit_vc        = (state == send_header && flit_count == '0) ? vc : vc_latched;
  assign any_valid      = (state == send_header) ? header_valid : payload_valid;
  assign selected_ready = flit_ready[flit_vc];
  assign flit_ack       = any_valid && selected_ready;

  always_comb begin
    flit_valid          = '0;
    flit_valid[flit_vc] = any_valid;  // only the packet's own channel sees valid
  end

  assign header_ready  = (state == send_header) && selected_ready && header_last;
  assign payload_ready = (state == send_payload) && selected_ready;

  always_comb begin
    if (state == send_header) begin
      flit_type = header_flit;
      head      = (flit_count == '0);
      tail      = no_payload && header_last;
      flit_data = header_data[flit_count*flit_data_width +: flit_data_width];
    end else begin
      flit_type = payload_flit;
      head      = 1'b0;
      tail      = payload_last;
      flit_data = '0;
      flit_data[payload_data_lsb +: $bits(noc_data)]       = data;
      flit_data[byte_enable_lsb +: $bits(noc_byte_enable)] = byte_enable;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= send_header;
      flit_count <= '0;
      vc_latched <= '0;
    end else if (flit_ack) begin
      if (head) begin
        vc_latched <= vc;
      end
      if (state == send_header) begin
        flit_count <= header_last ? '0 : flit_count + 1'b1;
      end
      if (tail) begin
        state <= send_header;
      end else if (state == send_header && header_last) begin
        state <= send_payload;
      end
    end
  end

  // channel must not move between the head flit and the tail flit
  assert property (@(posedge clk) disable iff (!rst_n)
    (|flit_valid && !head) |-> (vc == vc_latched))
    else $error("packer: vc changed inside a packet");

endmodule

// File: verilog/noc_pkg.sv
package noc_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int noc_vcs               = 2;
  localparam int flit_data_width       = 32;
  localparam int common_header_width   = 15;
  localparam int request_header_width  = 35;
  localparam int response_header_width = 17;
  localparam int request_header_flits  = 2;
  localparam int response_header_flits = 1;
  localparam int header_data_width     = 64;
  localparam int header_count_width    = $clog2(request_header_flits);
  localparam int vc_buffer_depth       = 4;
  localparam int buffer_pointer_width  = $clog2(vc_buffer_depth);

  // field positions inside the header and payload flits
  localparam int type_lsb         = 0;
  localparam int destination_lsb  = 2;
  localparam int source_lsb       = 6;
  localparam int vc_lsb           = 10;
  localparam int tag_lsb          = 11;
  localparam int burst_length_lsb = 15;
  localparam int address_lsb      = 19;
  localparam int status_lsb       = 15;   // responses only
  localparam int payload_data_lsb = 0;
  localparam int byte_enable_lsb  = 16;

  typedef logic [0:0]  noc_vc;
  typedef logic [3:0]  noc_id;
  typedef logic [3:0]  noc_tag;
  typedef logic [3:0]  noc_burst_length;  // beats minus one
  typedef logic [15:0] noc_address;
  typedef logic [1:0]  noc_status;
  typedef logic [15:0] noc_data;
  typedef logic [1:0]  noc_byte_enable;
  typedef logic [flit_data_width-1:0] noc_flit_data;

  typedef enum logic [1:0] {
    read_request,
    write_request,
    read_response,
    write_response
  } noc_packet_type;

  typedef enum logic {
    header_flit,
    payload_flit
  } noc_flit_type;

  function automatic logic is_request_packet_type(noc_packet_type packet_type);
    return (packet_type == read_request) || (packet_type == write_request);
  endfunction

  function automatic logic has_payload(noc_packet_type packet_type);
    return (packet_type == write_request) || (packet_type == read_response);
  endfunction

  // index of the final header flit for this packet type
  function automatic logic [header_count_width-1:0] last_header_flit(
    noc_packet_type packet_type
  );
    if (is_request_packet_type(packet_type)) begin
      return header_count_width'(request_header_flits - 1);
    end
    return header_count_width'(response_header_flits - 1);
  endfunction

endpackage
